/* verilog.f */
+incdir+tb
common/gpio_pkg.sv
apb_regs/gpio_apb_regs.sv
irq/gpio_irq_unit.sv
verilog/gpio_top.sv
tb/gpio_tb.sv

/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = gpio_tb
FLIST     = verilog.f
OBJ_DIR   = obj_dir

SRCS := $(wildcard common/*.sv verilog/*.sv apb_regs/*.sv irq/*.sv tb/*.sv tb/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# a $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tb/gpio_tb_checks.svh */
`ifndef GPIO_TB_CHECKS_SVH
`define GPIO_TB_CHECKS_SVH

   // --------------------
   // compare tasks
   // --------------------

   task automatic check_word(input string name, input logic [APB_WIDTH-1:0] expected,
                             input logic [APB_WIDTH-1:0] actual);
      if (actual !== expected)
      begin
         stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   task automatic check_pins(input string name, input logic [IO_NUM-1:0] expected,
                             input logic [IO_NUM-1:0] actual);
      if (actual !== expected)
      begin
         stop_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         stop_run($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
      end
   endtask

   // --------------------
   // apb master
   // --------------------

   // setup phase on one falling edge, access phase on the next
   task automatic apb_write(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [APB_WIDTH-1:0] data);
      psel    = 1'b1;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge PCLK);
      penable = 1'b1;
      @(negedge PCLK);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [ADDR_WIDTH-1:0] addr,
                           output logic [APB_WIDTH-1:0] data);
      psel    = 1'b1;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge PCLK);
      penable = 1'b1;
      // prdata is combinational, sample mid access phase
      #1;
      data = prdata;
      check_bit("pready", 1'b1, pready);
      check_bit("pslverr", 1'b0, pslverr);
      @(negedge PCLK);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

`endif

/* tb/gpio_tb.sv */
module gpio_tb;
   timeunit 1ns;
   timeprecision 100ps;

   import gpio_pkg::*;

   typedef enum {ACT_WRITE, ACT_READ, ACT_DRIVE, ACT_PINS, ACT_INT, ACT_IDLE} act_e;

   // for ACT_PINS, data holds the expected oe and expected the expected out
   typedef struct {
      string                 name;
      act_e                  act;
      logic [ADDR_WIDTH-1:0] addr;
      logic [APB_WIDTH-1:0]  data;
      logic [APB_WIDTH-1:0]  expected;
   } step_t;

   logic                  PCLK = 1'b0;
   logic                  aresetn;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [ADDR_WIDTH-1:0] paddr;
   logic [APB_WIDTH-1:0]  pwdata;
   logic [APB_WIDTH-1:0]  prdata;
   logic                  pready;
   logic                  pslverr;
   logic [IO_NUM-1:0]     gpio_in;
   logic [IO_NUM-1:0]     gpio_out;
   logic [IO_NUM-1:0]     gpio_oe;
   logic [IO_NUM-1:0]     int_vec;
   logic                  int_or;

   step_t                 steps [$];
   // config bytes as software wrote them
   logic [CFG_WIDTH-1:0]  cfg_m [IO_NUM];
   bit                    table_ready;

   gpio_top dut0 (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_vec),
      .int_or_o   (int_or)
   );

   initial
   begin
      forever #4 PCLK = ~PCLK;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped");
   endtask

`include "gpio_tb_checks.svh"

   // --------------------
   // reference model
   // --------------------

   function automatic logic [IO_NUM-1:0] cfg_column(input int pos);
      logic [IO_NUM-1:0] v;
      for (int i = 0; i < IO_NUM; i++)
      begin
         v[i] = cfg_m[i][pos];
      end
      return v;
   endfunction

   function automatic logic [CFG_WIDTH-1:0] make_cfg(input logic out_en, input logic in_en,
                                                     input logic oe, input logic int_en,
                                                     input irq_type_e kind);
      logic [CFG_WIDTH-1:0] b;
      b                      = '0;
      b[CFG_OUT_EN]          = out_en;
      b[CFG_IN_EN]           = in_en;
      b[CFG_OE]              = oe;
      b[CFG_INT_EN]          = int_en;
      b[CFG_TYPE_LSB +: 3]   = kind;
      return b;
   endfunction

   function automatic logic [APB_WIDTH-1:0] one_hot(input int pin);
      return APB_WIDTH'(1) << pin;
   endfunction

   // --------------------
   // table helpers
   // --------------------

   task automatic wr_step(input string name, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [APB_WIDTH-1:0] data);
      steps.push_back('{name, ACT_WRITE, addr, data, '0});
   endtask

   task automatic rd_step(input string name, input logic [ADDR_WIDTH-1:0] addr,
                          input logic [APB_WIDTH-1:0] expected);
      steps.push_back('{name, ACT_READ, addr, '0, expected});
   endtask

   task automatic int_step(input string name, input logic [APB_WIDTH-1:0] expected);
      steps.push_back('{name, ACT_INT, '0, '0, expected});
   endtask

   task automatic idle_step(input int cycles);
      steps.push_back('{"idle", ACT_IDLE, '0, APB_WIDTH'(cycles), '0});
   endtask

   task automatic drive_step(input logic [IO_NUM-1:0] level);
      steps.push_back('{"drive", ACT_DRIVE, '0, APB_WIDTH'(level), '0});
   endtask

   task automatic cfg_write(input int pin, input logic [CFG_WIDTH-1:0] value);
      cfg_m[pin] = value;
      wr_step($sformatf("cfg %0d write", pin), ADDR_WIDTH'(pin * 4), APB_WIDTH'(value));
   endtask

   task automatic cfg_read(input int pin);
      rd_step($sformatf("cfg %0d read", pin), ADDR_WIDTH'(pin * 4), APB_WIDTH'(cfg_m[pin]));
   endtask

   task automatic build_table();
      logic [APB_WIDTH-1:0] word;
      int                   rand_pins [4] = '{0, 31, 7, 18};

      // reset values
      for (int i = 0; i < IO_NUM; i++)
      begin
         cfg_m[i] = '0;
         cfg_read(i);
      end
      rd_step("gpout reset", OFFS_GPOUT, GPOUT_RESET);
      rd_step("intr reset", OFFS_INTR, '0);
      rd_step("unmapped read", 8'hB0, '0);
      steps.push_back('{"pins reset", ACT_PINS, '0, '0, '0});
      int_step("int reset", '0);

      // random config bytes, interrupt enable left clear on these pins
      foreach (rand_pins[k])
      begin
         cfg_write(rand_pins[k], CFG_WIDTH'($urandom) & ~(CFG_WIDTH'(1) << CFG_INT_EN));
      end
      foreach (rand_pins[k])
      begin
         cfg_read(rand_pins[k]);
      end
      cfg_read(1);
      cfg_read(30);
      cfg_read(19);

      // output drive
      cfg_write(2, make_cfg(1'b1, 1'b0, 1'b1, 1'b0, IRQ_DISABLED));
      cfg_write(3, make_cfg(1'b1, 1'b0, 1'b0, 1'b0, IRQ_DISABLED));
      cfg_write(4, make_cfg(1'b0, 1'b0, 1'b1, 1'b0, IRQ_DISABLED));
      word = $urandom;
      wr_step("gpout write", OFFS_GPOUT, word);
      rd_step("gpout read", OFFS_GPOUT, word);
      steps.push_back('{"pin drive", ACT_PINS, '0,
                        APB_WIDTH'(cfg_column(CFG_OUT_EN) & cfg_column(CFG_OE)),
                        APB_WIDTH'(word[IO_NUM-1:0] & cfg_column(CFG_OUT_EN))});

      // input path, three edges to the gpin register
      cfg_write(8, make_cfg(1'b0, 1'b1, 1'b0, 1'b0, IRQ_DISABLED));
      cfg_write(9, make_cfg(1'b0, 1'b1, 1'b0, 1'b0, IRQ_DISABLED));
      word = $urandom;
      drive_step(word);
      idle_step(2);
      rd_step("gpin read", OFFS_GPIN, APB_WIDTH'(word[IO_NUM-1:0] & cfg_column(CFG_IN_EN)));

      // level interrupts
      drive_step('0);
      idle_step(3);
      cfg_write(10, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_LEVEL_HIGH));
      cfg_write(11, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_LEVEL_LOW));
      cfg_write(12, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_DISABLED));
      cfg_write(13, make_cfg(1'b0, 1'b0, 1'b0, 1'b0, IRQ_LEVEL_LOW));
      cfg_write(14, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, irq_type_e'(3'd5)));
      int_step("level low", one_hot(11));
      drive_step(one_hot(10) | one_hot(11) | one_hot(12) | one_hot(13) | one_hot(14));
      idle_step(2);
      int_step("level high", one_hot(10));
      wr_step("clear level", OFFS_INTR, one_hot(10));
      int_step("level kept", one_hot(10));
      rd_step("status kept", OFFS_INTR, one_hot(10));
      drive_step('0);
      idle_step(2);
      int_step("level low again", one_hot(11));
      cfg_write(10, '0);
      cfg_write(11, '0);
      int_step("levels off", '0);

      // edge latches
      cfg_write(20, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_EDGE_POS));
      cfg_write(21, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_EDGE_NEG));
      cfg_write(22, make_cfg(1'b0, 1'b0, 1'b0, 1'b1, IRQ_EDGE_BOTH));
      cfg_write(23, make_cfg(1'b0, 1'b0, 1'b0, 1'b0, IRQ_EDGE_BOTH));
      int_step("edges quiet", '0);
      drive_step(one_hot(20));
      drive_step('0);
      idle_step(3);
      int_step("rise latched", one_hot(20));
      idle_step(4);
      int_step("rise held", one_hot(20));
      drive_step(one_hot(21));
      idle_step(3);
      int_step("rise on neg pin", one_hot(20));
      drive_step('0);
      drive_step(one_hot(21));
      idle_step(3);
      int_step("fall latched", one_hot(20) | one_hot(21));
      drive_step(one_hot(21) | one_hot(22) | one_hot(23));
      idle_step(3);
      int_step("both on rise", one_hot(20) | one_hot(21) | one_hot(22));
      rd_step("edge status", OFFS_INTR, one_hot(20) | one_hot(21) | one_hot(22));
      wr_step("clear both", OFFS_INTR, one_hot(22));
      int_step("both cleared", one_hot(20) | one_hot(21));
      drive_step(one_hot(21));
      idle_step(3);
      int_step("both on fall", one_hot(20) | one_hot(21) | one_hot(22));
      wr_step("clear edges", OFFS_INTR, one_hot(20) | one_hot(21) | one_hot(22));
      int_step("edges cleared", '0);
      idle_step(1);
      rd_step("status cleared", OFFS_INTR, '0);
   endtask

   task automatic apply_step(input step_t s);
      logic [APB_WIDTH-1:0] rd;
      case (s.act)
         ACT_WRITE: apb_write(s.addr, s.data);
         ACT_READ:
         begin
            apb_read(s.addr, rd);
            check_word(s.name, s.expected, rd);
         end
         ACT_DRIVE:
         begin
            gpio_in = s.data[IO_NUM-1:0];
            @(negedge PCLK);
         end
         ACT_PINS:
         begin
            check_pins({s.name, " out"}, s.expected[IO_NUM-1:0], gpio_out);
            check_pins({s.name, " oe"}, s.data[IO_NUM-1:0], gpio_oe);
         end
         ACT_INT:
         begin
            check_pins(s.name, s.expected[IO_NUM-1:0], int_vec);
            // summary line is the OR of all pin lines
            check_bit({s.name, " or"}, |s.expected[IO_NUM-1:0], int_or);
         end
         ACT_IDLE: repeat (s.data) @(negedge PCLK);
         default: stop_run("unknown action in the step table");
      endcase
   endtask

   // --------------------
   // main sequence
   // --------------------

   initial
   begin
      void'($urandom(38924));
      aresetn = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(negedge PCLK);
      aresetn = 1'b1;
      foreach (steps[n])
      begin
         apply_step(steps[n]);
      end
      $display(">>> PASS");
      $finish;
   end

   // watchdog, sized from the table
   initial
   begin
      wait (table_ready);
      repeat (steps.size() * 10 + 100) @(posedge PCLK);
      stop_run("timeout: the step table did not finish in time");
   end

endmodule

/* verilog/gpio_top.sv */
module gpio_top (
   input  logic                             PCLK,
   input  logic                             aresetn,
   // apb slave
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [gpio_pkg::ADDR_WIDTH-1:0]  paddr_i,
   input  logic [gpio_pkg::APB_WIDTH-1:0]   pwdata_i,
   output logic [gpio_pkg::APB_WIDTH-1:0]   prdata_o,
   output logic                             pready_o,
   output logic                             pslverr_o,
   // pins
   input  logic [gpio_pkg::IO_NUM-1:0]      gpio_in_i,
   output logic [gpio_pkg::IO_NUM-1:0]      gpio_out_o,
   output logic [gpio_pkg::IO_NUM-1:0]      gpio_oe_o,
   // interrupts
   output logic [gpio_pkg::IO_NUM-1:0]      int_o,
   output logic                             int_or_o
);
   import gpio_pkg::*;

   logic [IO_NUM-1:0]    cfg_int_en;
   irq_type_e            cfg_int_type [IO_NUM];
   logic                 intr_clr_we;
   logic [APB_WIDTH-1:0] clr_mask;
   logic [IO_NUM-1:0]    gpin_sync;
   logic [IO_NUM-1:0]    intr_status;

   // every access completes in its access phase
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_apb_regs u_regs (
      .PCLK           (PCLK),
      .aresetn        (aresetn),
      .psel_i         (psel_i),
      .penable_i      (penable_i),
      .pwrite_i       (pwrite_i),
      .paddr_i        (paddr_i),
      .pwdata_i       (pwdata_i),
      .prdata_o       (prdata_o),
      .gpin_sync_i    (gpin_sync),
      .intr_status_i  (intr_status),
      .cfg_int_en_o   (cfg_int_en),
      .cfg_int_type_o (cfg_int_type),
      .intr_clr_we_o  (intr_clr_we),
      .clr_mask_o     (clr_mask),
      .gpio_out_o     (gpio_out_o),
      .gpio_oe_o      (gpio_oe_o)
   );

   gpio_irq_unit u_irq (
      .PCLK           (PCLK),
      .aresetn        (aresetn),
      .gpio_in_i      (gpio_in_i),
      .cfg_int_en_i   (cfg_int_en),
      .cfg_int_type_i (cfg_int_type),
      .intr_clr_we_i  (intr_clr_we),
      .clr_mask_i     (clr_mask),
      .gpin_sync_o    (gpin_sync),
      .intr_status_o  (intr_status),
      .int_o          (int_o),
      .int_or_o       (int_or_o)
   );

endmodule

/* irq/gpio_irq_unit.sv */
module gpio_irq_unit (
   input  logic                             PCLK,
   input  logic                             aresetn,
   // pins
   input  logic [gpio_pkg::IO_NUM-1:0]      gpio_in_i,
   // config from the register block
   input  logic [gpio_pkg::IO_NUM-1:0]      cfg_int_en_i,
   input  gpio_pkg::irq_type_e              cfg_int_type_i [gpio_pkg::IO_NUM],
   input  logic                             intr_clr_we_i,
   input  logic [gpio_pkg::APB_WIDTH-1:0]   clr_mask_i,
   // read-back
   output logic [gpio_pkg::IO_NUM-1:0]      gpin_sync_o,
   output logic [gpio_pkg::IO_NUM-1:0]      intr_status_o,
   // interrupts
   output logic [gpio_pkg::IO_NUM-1:0]      int_o,
   output logic                             int_or_o
);
   import gpio_pkg::*;

   logic [IO_NUM-1:0] sync1_q;
   logic [IO_NUM-1:0] sync2_q;
   logic [IO_NUM-1:0] dly_q;

   logic [IO_NUM-1:0] rise;
   logic [IO_NUM-1:0] fall;
   logic [IO_NUM-1:0] clr;

   logic [IO_NUM-1:0] edge_pos_q;
   logic [IO_NUM-1:0] edge_neg_q;
   logic [IO_NUM-1:0] edge_both_q;

   logic [IO_NUM-1:0] int_src;

   // --------------------
   // input path
   // --------------------

   // two flops against metastability, then one delay for edge detect
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         sync1_q <= '0;
         sync2_q <= '0;
         dly_q   <= '0;
      end
      else
      begin
         sync1_q <= gpio_in_i;
         sync2_q <= sync1_q;
         dly_q   <= sync2_q;
      end
   end

   assign gpin_sync_o = dly_q;

   // new level against the delayed one
   assign rise = sync2_q & ~dly_q;
   assign fall = ~sync2_q & dly_q;

   // w1c bits for this cycle
   assign clr  = intr_clr_we_i ? clr_mask_i[IO_NUM-1:0] : '0;

   // --------------------
   // edge latches
   // --------------------

   for (genvar i = 0; i < IO_NUM; i++)
   begin : g_pin
      // held at zero while the pin's interrupt is off
      // a new edge wins over a clear in the same cycle
      always_ff @(posedge PCLK or negedge aresetn)
      begin
         if (!aresetn)
         begin
            edge_pos_q[i]  <= 1'b0;
            edge_neg_q[i]  <= 1'b0;
            edge_both_q[i] <= 1'b0;
         end
         else if (!cfg_int_en_i[i])
         begin
            edge_pos_q[i]  <= 1'b0;
            edge_neg_q[i]  <= 1'b0;
            edge_both_q[i] <= 1'b0;
         end
         else
         begin
            edge_pos_q[i]  <= rise[i] | (edge_pos_q[i] & ~clr[i]);
            edge_neg_q[i]  <= fall[i] | (edge_neg_q[i] & ~clr[i]);
            edge_both_q[i] <= rise[i] | fall[i] | (edge_both_q[i] & ~clr[i]);
         end
      end

      // source select by type, unused codes never fire
      always_comb
      begin
         case (cfg_int_type_i[i])
            IRQ_LEVEL_HIGH: int_src[i] = dly_q[i];
            IRQ_LEVEL_LOW:  int_src[i] = ~dly_q[i];
            IRQ_EDGE_POS:   int_src[i] = edge_pos_q[i];
            IRQ_EDGE_NEG:   int_src[i] = edge_neg_q[i];
            IRQ_EDGE_BOTH:  int_src[i] = edge_both_q[i];
            default:        int_src[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_src & cfg_int_en_i;
   assign int_or_o = |int_o;

   // --------------------
   // interrupt status
   // --------------------

   // reloads from int_o, so a held level comes back after a clear
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         intr_status_o <= '0;
      end
      else if (intr_clr_we_i)
      begin
         intr_status_o <= intr_status_o & ~clr_mask_i[IO_NUM-1:0];
      end
      else
      begin
         intr_status_o <= int_o;
      end
   end

   // --------------------
   // assertions
   // --------------------

   // no stale edge survives on a pin that was disabled
   a_latch_off : assert property (
      @(posedge PCLK) disable iff (!aresetn)
      ((edge_pos_q | edge_neg_q | edge_both_q) & ~$past(cfg_int_en_i)) == '0
   );

   // gpin shows the pin level three edges back
   a_in_latency : assert property (
      @(posedge PCLK) disable iff (!aresetn)
      $past(aresetn, 3) |-> (gpin_sync_o == $past(gpio_in_i, 3))
   );

endmodule

/* apb_regs/gpio_apb_regs.sv */
module gpio_apb_regs (
   input  logic                             PCLK,
   input  logic                             aresetn,
   // apb slave
   input  logic                             psel_i,
   input  logic                             penable_i,
   input  logic                             pwrite_i,
   input  logic [gpio_pkg::ADDR_WIDTH-1:0]  paddr_i,
   input  logic [gpio_pkg::APB_WIDTH-1:0]   pwdata_i,
   output logic [gpio_pkg::APB_WIDTH-1:0]   prdata_o,
   // read-back from the interrupt unit
   input  logic [gpio_pkg::IO_NUM-1:0]      gpin_sync_i,
   input  logic [gpio_pkg::IO_NUM-1:0]      intr_status_i,
   // config towards the interrupt unit
   output logic [gpio_pkg::IO_NUM-1:0]      cfg_int_en_o,
   output gpio_pkg::irq_type_e              cfg_int_type_o [gpio_pkg::IO_NUM],
   output logic                             intr_clr_we_o,
   output logic [gpio_pkg::APB_WIDTH-1:0]   clr_mask_o,
   // pins
   output logic [gpio_pkg::IO_NUM-1:0]      gpio_out_o,
   output logic [gpio_pkg::IO_NUM-1:0]      gpio_oe_o
);
   import gpio_pkg::*;

   logic [CFG_WIDTH-1:0]        cfg_q [IO_NUM];
   logic [APB_WIDTH-1:0]        gpout_q;

   logic                        wr_en;
   logic                        cfg_hit;
   logic [$clog2(IO_NUM)-1:0]   addr_idx;

   logic [IO_NUM-1:0]           out_en;
   logic [IO_NUM-1:0]           in_en;
   logic [IO_NUM-1:0]           oe_bit;

   // --------------------
   // address decode
   // --------------------

   // write strobe, end of access phase
   assign wr_en    = psel_i & penable_i & pwrite_i;

   // word address picks the pin below the status block
   assign cfg_hit  = (paddr_i < OFFS_CFG_LIMIT);
   assign addr_idx = paddr_i[2 +: $clog2(IO_NUM)];

   // w1c pulse and mask for the interrupt unit
   assign intr_clr_we_o = wr_en && (paddr_i == OFFS_INTR);
   assign clr_mask_o    = pwdata_i;

   // --------------------
   // config registers
   // --------------------

   for (genvar i = 0; i < IO_NUM; i++)
   begin : g_cfg
      always_ff @(posedge PCLK or negedge aresetn)
      begin
         if (!aresetn)
         begin
            cfg_q[i] <= '0;
         end
         else if (wr_en && cfg_hit && (addr_idx == i))
         begin
            cfg_q[i] <= pwdata_i[CFG_WIDTH-1:0];
         end
      end

      // split out the fields
      assign out_en[i]         = cfg_q[i][CFG_OUT_EN];
      assign in_en[i]          = cfg_q[i][CFG_IN_EN];
      assign oe_bit[i]         = cfg_q[i][CFG_OE];
      assign cfg_int_en_o[i]   = cfg_q[i][CFG_INT_EN];
      assign cfg_int_type_o[i] = irq_type_e'(cfg_q[i][CFG_TYPE_LSB +: 3]);
   end

   // --------------------
   // output data
   // --------------------

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpout_q <= GPOUT_RESET;
      end
      else if (wr_en && (paddr_i == OFFS_GPOUT))
      begin
         gpout_q <= pwdata_i;
      end
   end

   // pin drive, data only reaches a pin with its output register enabled
   assign gpio_out_o = gpout_q[IO_NUM-1:0] & out_en;
   assign gpio_oe_o  = out_en & oe_bit;

   // --------------------
   // read data
   // --------------------

   always_comb
   begin
      if (cfg_hit)
      begin
         prdata_o = APB_WIDTH'(cfg_q[addr_idx]);
      end
      else if (paddr_i == OFFS_INTR)
      begin
         prdata_o = APB_WIDTH'(intr_status_i);
      end
      else if (paddr_i == OFFS_GPIN)
      begin
         // only enabled inputs are visible
         prdata_o = APB_WIDTH'(gpin_sync_i & in_en);
      end
      else if (paddr_i == OFFS_GPOUT)
      begin
         prdata_o = gpout_q;
      end
      else
      begin
         prdata_o = '0;
      end
   end

   // --------------------
   // assertions
   // --------------------

   // a config write with the output register off releases the pin
   for (genvar i = 0; i < IO_NUM; i++)
   begin : g_chk
      a_oe_needs_out_en : assert property (
         @(posedge PCLK) disable iff (!aresetn)
         (wr_en && cfg_hit && (addr_idx == i) && !pwdata_i[CFG_OUT_EN]) |=> !gpio_oe_o[i]
      );
   end

endmodule

/* common/gpio_pkg.sv */
package gpio_pkg;

   // --------------------
   // sizes
   // --------------------

   // one pin per data bit
   localparam int IO_NUM     = 32;
   localparam int APB_WIDTH  = 32;
   localparam int ADDR_WIDTH = 8;

   // per-pin config byte
   localparam int CFG_WIDTH  = 8;

   // --------------------
   // register map
   // --------------------

   // config bytes sit word-aligned below this offset
   localparam logic [7:0] OFFS_CFG_LIMIT = 8'h80;

   // interrupt status, write one to clear
   localparam logic [7:0] OFFS_INTR      = 8'h80;

   // synchronized input, masked by input enable
   localparam logic [7:0] OFFS_GPIN      = 8'h90;

   // output data
   localparam logic [7:0] OFFS_GPOUT     = 8'hA0;

   // --------------------
   // config byte fields
   // --------------------

   localparam int CFG_OUT_EN   = 0;
   localparam int CFG_IN_EN    = 1;
   localparam int CFG_OE       = 2;
   localparam int CFG_INT_EN   = 3;

   // bits 7:5 hold the interrupt type
   localparam int CFG_TYPE_LSB = 5;

   // output data after reset
   localparam logic [APB_WIDTH-1:0] GPOUT_RESET = '0;

   // interrupt source select, codes 5 and 6 behave as disabled
   typedef enum logic [2:0] {
      IRQ_LEVEL_HIGH = 3'd0,
      IRQ_LEVEL_LOW  = 3'd1,
      IRQ_EDGE_POS   = 3'd2,
      IRQ_EDGE_NEG   = 3'd3,
      IRQ_EDGE_BOTH  = 3'd4,
      IRQ_DISABLED   = 3'd7
   } irq_type_e;

endpackage
